// ==== Bender.yml ====
package:
  name: sram_bist

sources:
  - source/sramPkg.sv
  - source/mbistPkg.sv
  - source/tpSram.sv
  - source/tpSramWrap.sv
  - source/marchAddrGen.sv
  - source/marchFsm.sv
  - source/marchDataChk.sv
  - source/sramBistTop.sv
  - target: test
    files:
      - dv/bistChecker.sv
      - dv/tbSramBist.sv

// ==== all.f ====
source/sramPkg.sv
source/mbistPkg.sv
source/tpSram.sv
source/tpSramWrap.sv
source/marchAddrGen.sv
source/marchFsm.sv
source/marchDataChk.sv
source/sramBistTop.sv
dv/bistChecker.sv
dv/tbSramBist.sv

// ==== dv/bistChecker.sv ====
// Scoreboard for sramBistTop; assumes the retention bit stays constant through a BIST run and all words are written before the first read

module bistChecker #(
   parameter int memDepth  = 32,
   parameter int addrWidth = 5,
   parameter int dataWidth = 80
) (
   input  logic                            clk,
   input  logic                            rstN,
   input  logic                            start,
   input  logic [sramPkg::ConfigWidth-1:0] tpramConfig,
   input  logic                            fWeN,
   input  logic [addrWidth-1:0]            fWaddr,
   input  logic [dataWidth-1:0]            fDin,
   input  logic                            fReN,
   input  logic [addrWidth-1:0]            fRaddr,
   input  logic [dataWidth-1:0]            q,
   input  logic                            busy,
   input  logic                            done,
   input  logic                            fail,
   input  logic [addrWidth-1:0]            failAddr,
   input  logic [dataWidth-1:0]            failData,
   output int                              errCount
);
   import sramPkg::*;

   localparam int RunCycles = 20 * memDepth + 2;   // Start cycle to done

   logic [dataWidth-1:0] model [memDepth];
   logic [dataWidth-1:0] expQ;
   logic                 rdPend;
   logic                 inReset;
   logic                 running;
   logic                 runRetN;
   int                   cyc;
   int                   runStart;
   int                   k;
   logic                 holdFail;      // Result expected to stay until next start
   logic [addrWidth-1:0] holdAddr;
   logic [dataWidth-1:0] holdData;

   initial begin
      errCount = 0;
      rdPend   = 1'b0;
      inReset  = 1'b0;
      running  = 1'b0;
      runRetN  = 1'b1;
      cyc      = 0;
      runStart = 0;
      holdFail = 1'b0;
      holdAddr = '0;
      holdData = '0;
   end

   task automatic reportErr(input string msg);
      $display("ERR @%0t: %s", $time, msg);
      errCount++;
   endtask

   function automatic logic [dataWidth-1:0] checkerWord();
      logic [dataWidth-1:0] w;
      for (int i = 0; i < dataWidth; i++) begin
         w[i] = (i % 2 == 1);   // Bit 0 low
      end
      return w;
   endfunction

   task automatic finishRun(input int cycles);
      logic                 expFail;
      logic [addrWidth-1:0] expAddr;
      logic [dataWidth-1:0] expData;
      int                   a;
      expFail = 1'b0;
      expAddr = '0;
      expData = '0;
      if (cycles != RunCycles) begin
         reportErr($sformatf("done after %0d cycles, expected %0d", cycles, RunCycles));
      end
      if (busy) begin
         reportErr("busy still high in the done cycle");
      end
      if (!runRetN) begin
         // Writes held off, so the first up read of a nonzero word fails
         // An all-zero array fails at address 0 on the inverse read
         expFail = 1'b1;
         for (a = memDepth - 1; a >= 0; a--) begin
            if (model[a] != '0) begin
               expAddr = addrWidth'(a);
               expData = model[a];
            end
         end
      end else begin
         for (a = 0; a < memDepth; a++) begin
            model[a] = checkerWord();   // Last write of the run
         end
      end
      if (fail !== expFail || failAddr !== expAddr || failData !== expData) begin
         reportErr($sformatf("fail %b addr %0d data %h, expected %b addr %0d data %h",
                             fail, failAddr, failData, expFail, expAddr, expData));
      end
      holdFail = expFail;
      holdAddr = expAddr;
      holdData = expData;
      running  = 1'b0;
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Model update on the rising edge
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always @(posedge clk) begin
      cyc++;
      rdPend = 1'b0;
      if (!rstN) begin
         inReset = 1'b1;
         running = 1'b0;
      end else if (!busy) begin
         if (!fReN) begin
            rdPend = 1'b1;
            expQ   = model[fRaddr];   // Old word on a same-edge write
         end
         if (!fWeN && tpramConfig[CfgRetBit]) begin
            model[fWaddr] = fDin;
         end
         if (start) begin
            running  = 1'b1;
            runStart = cyc;
            runRetN  = tpramConfig[CfgRetBit];
         end
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Output checks on the falling edge
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always @(negedge clk) begin
      if (!rstN) begin
         if (inReset && (busy !== 1'b0 || done !== 1'b0 || fail !== 1'b0 ||
                         failAddr !== '0 || failData !== '0)) begin
            reportErr("outputs not at their reset values");
         end
      end else begin
         if (rdPend && q !== expQ) begin
            reportErr($sformatf("read data %h, expected %h", q, expQ));
         end
         if (running) begin
            k = cyc - runStart + 1;   // Start cycle is cycle 0
            if (done) begin
               finishRun(k);
            end else if (k > RunCycles) begin
               $display("BIST run ended without a done pulse");
               errCount++;
               running = 1'b0;
            end else if (!busy) begin
               reportErr("busy low during a BIST run");
            end else if (k == 1 && (fail || failAddr != '0 || failData != '0)) begin
               reportErr("failure record not cleared by start");
            end
         end else if (busy !== 1'b0 || done !== 1'b0 || fail !== holdFail ||
                      failAddr !== holdAddr || failData !== holdData) begin
            reportErr("BIST outputs changed while idle");
         end
      end
   end

endmodule

// ==== dv/tbSramBist.sv ====
// Testbench at the default geometry only; fixed LCG seed, all checking sits in bistChecker

module tbSramBist;
   import sramPkg::*;

   localparam int memDepth     = MemDepthDef;
   localparam int addrWidth    = AddrWidthDef;
   localparam int dataWidth    = DataWidthDef;
   localparam int RunCycles    = 20 * memDepth + 2;
   localparam int ClkPeriod    = 100;
   localparam int WatchdogTime = (4 * RunCycles + 600 + 100) * ClkPeriod;   // 100 cycles margin

   logic                   clk;
   logic                   rstN;
   logic                   start;
   logic [ConfigWidth-1:0] tpramConfig;
   logic                   fWeN;
   logic [addrWidth-1:0]   fWaddr;
   logic [dataWidth-1:0]   fDin;
   logic                   fReN;
   logic [addrWidth-1:0]   fRaddr;
   logic [dataWidth-1:0]   q;
   logic                   busy;
   logic                   done;
   logic                   fail;
   logic [addrWidth-1:0]   failAddr;
   logic [dataWidth-1:0]   failData;
   int                     errCount;
   logic [31:0]            seed = 32'h9700_217d;
   int                     testNum = 0;
   int                     passCnt = 0;
   int                     failCnt = 0;
   int                     lastErr = 0;

   sramBistTop #(
      .memDepth (memDepth),
      .addrWidth(addrWidth),
      .dataWidth(dataWidth)
   ) sramBistTop_i (
      .clk        (clk),
      .rstN       (rstN),
      .start      (start),
      .tpramConfig(tpramConfig),
      .fWeN       (fWeN),
      .fWaddr     (fWaddr),
      .fDin       (fDin),
      .fReN       (fReN),
      .fRaddr     (fRaddr),
      .q          (q),
      .busy       (busy),
      .done       (done),
      .fail       (fail),
      .failAddr   (failAddr),
      .failData   (failData)
   );

   bistChecker #(
      .memDepth (memDepth),
      .addrWidth(addrWidth),
      .dataWidth(dataWidth)
   ) uBistChecker (
      .clk        (clk),
      .rstN       (rstN),
      .start      (start),
      .tpramConfig(tpramConfig),
      .fWeN       (fWeN),
      .fWaddr     (fWaddr),
      .fDin       (fDin),
      .fReN       (fReN),
      .fRaddr     (fRaddr),
      .q          (q),
      .busy       (busy),
      .done       (done),
      .fail       (fail),
      .failAddr   (failAddr),
      .failData   (failData),
      .errCount   (errCount)
   );

   initial begin
      clk = 1'b0;
      forever #(ClkPeriod / 2) clk = ~clk;
   end

   initial begin
      #(WatchdogTime);
      $display("Watchdog expired before the tests finished");
      $display("TESTS FAILED");
      $finish;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Random numbers and drivers
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   function automatic logic [31:0] nextRand();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   function automatic logic [dataWidth-1:0] randWord();
      logic [dataWidth-1:0] w;
      w = '0;
      for (int i = 0; i < dataWidth; i += 16) begin
         w = (w << 16) | (nextRand() >> 16);   // Upper LCG bits only
      end
      return w;
   endfunction

   task automatic driveCycle(input logic weN, input logic [addrWidth-1:0] wa,
                             input logic [dataWidth-1:0] wd, input logic reN,
                             input logic [addrWidth-1:0] ra);
      @(negedge clk);
      fWeN   = weN;
      fWaddr = wa;
      fDin   = wd;
      fReN   = reN;
      fRaddr = ra;
      start  = 1'b0;
   endtask

   task automatic readAll();
      for (int a = 0; a < memDepth; a++) begin
         driveCycle(1'b1, '0, '0, 1'b0, addrWidth'(a));
      end
      driveCycle(1'b1, '0, '0, 1'b1, '0);
   endtask

   task automatic runBist(input logic retN);
      logic [31:0] r;
      int          n;
      @(negedge clk);
      fWeN        = 1'b1;
      fReN        = 1'b1;
      start       = 1'b1;
      tpramConfig = ConfigWidth'(nextRand() >> 20);   // Random margins
      tpramConfig[CfgRetBit] = retN;
      n = 0;
      do begin
         @(negedge clk);
         r      = nextRand();
         start  = 1'b0;
         fWeN   = !(busy && r[31]);   // Requests only while busy, all dropped
         fReN   = !(busy && r[30]);
         fWaddr = addrWidth'(r >> 16);
         fRaddr = addrWidth'(r >> 8);
         fDin   = randWord();
         n++;
      end while (!done && n < RunCycles + 20);
      fWeN = 1'b1;
      fReN = 1'b1;
   endtask

   task automatic endTest(input string name);
      @(posedge clk);   // Checker has done its falling-edge compare by now
      testNum++;
      if (errCount == lastErr) begin
         passCnt++;
         $display("Test %0d %s: ok", testNum, name);
      end else begin
         failCnt++;
         $display("Test %0d %s: %0d errors", testNum, name, errCount - lastErr);
      end
      lastErr = errCount;
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Test sequence
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   initial begin
      logic [31:0]          r;
      logic [dataWidth-1:0] w;
      logic [addrWidth-1:0] lastWa;
      int                   zeroAddr;
      rstN        = 1'b0;
      start       = 1'b0;
      tpramConfig = '0;
      tpramConfig[CfgRetBit] = 1'b1;
      fWeN        = 1'b1;
      fWaddr      = '0;
      fDin        = '0;
      fReN        = 1'b1;
      fRaddr      = '0;
      repeat (8) @(negedge clk);
      rstN = 1'b1;
      repeat (3) driveCycle(1'b1, '0, '0, 1'b1, '0);
      endTest("reset values");

      for (int a = 0; a < memDepth; a++) begin
         driveCycle(1'b0, addrWidth'(a), randWord(), 1'b1, '0);
      end
      lastWa = '0;
      repeat (150) begin
         r = nextRand();
         w = randWord();
         driveCycle(r[31], addrWidth'(r >> 16), w, r[30], r[29] ? lastWa : addrWidth'(r >> 8));
         if (!r[31]) lastWa = addrWidth'(r >> 16);
      end
      driveCycle(1'b0, lastWa, randWord(), 1'b1, '0);
      driveCycle(1'b1, '0, '0, 1'b0, lastWa);   // Read back last cycle's write
      driveCycle(1'b1, '0, '0, 1'b1, '0);
      endTest("functional writes and reads");

      runBist(1'b1);
      readAll();
      endTest("BIST pass and checkerboard readback");

      zeroAddr = 0;   // Word 0 reads back clean so the first failure lands above it
      for (int a = 0; a < memDepth; a++) begin
         w = randWord();
         if (a == zeroAddr) begin
            w = '0;
         end else if (w == '0) begin
            w[0] = 1'b1;
         end
         driveCycle(1'b0, addrWidth'(a), w, 1'b1, '0);
      end
      runBist(1'b0);
      readAll();
      endTest("BIST fail under retention");

      runBist(1'b1);
      readAll();
      endTest("BIST rerun clears fail");

      $display("Summary: %0d tests ok, %0d tests with errors, %0d errors total",
               passCnt, failCnt, errCount);
      if (failCnt == 0 && errCount == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== source/marchAddrGen.sv ====
// March address counter; memDepth must be a power of two and a load takes priority over a step

module marchAddrGen #(
   parameter int memDepth  = 32,
   parameter int addrWidth = 5
) (
   input  logic                 clk,
   input  logic                 rstN,
   input  logic                 addrLoad,
   input  logic                 addrStep,
   input  logic                 addrDown,
   output logic [addrWidth-1:0] addr,
   output logic                 addrLast
);

   localparam logic [addrWidth-1:0] TopAddr = addrWidth'(memDepth - 1);

   logic dirDown;   // Direction latched at load

   always_ff @(posedge clk) begin
      if (!rstN) begin
         addr    <= '0;
         dirDown <= 1'b0;
      end else if (addrLoad) begin
         addr    <= addrDown ? TopAddr : '0;
         dirDown <= addrDown;
      end else if (addrStep) begin
         if (dirDown) begin
            addr <= addr - 1'b1;
         end else begin
            addr <= addr + 1'b1;
         end
      end
   end

   // Final address for the direction in use, so the FSM can load ahead
   always_comb begin
      if (dirDown) begin
         addrLast = (addr == '0);
      end else begin
         addrLast = (addr == TopAddr);
      end
   end

endmodule

// ==== source/marchDataChk.sv ====
// Pattern builder and read checker; expects read data exactly one cycle after the read and keeps only the first mismatch

module marchDataChk #(
   parameter int addrWidth = 5,
   parameter int dataWidth = 80
) (
   input  logic                 clk,
   input  logic                 rstN,
   input  logic                 start,
   input  logic                 bistOpValid,
   input  mbistPkg::marchOpT    bistOp,
   input  logic                 invert,
   input  mbistPkg::backgroundT bg,
   input  logic [addrWidth-1:0] addr,
   input  logic [dataWidth-1:0] q,
   output logic [dataWidth-1:0] bistDin,
   output logic                 fail,
   output logic [addrWidth-1:0] failAddr,
   output logic [dataWidth-1:0] failData
);
   import mbistPkg::*;

   logic [dataWidth-1:0] ckPattern;
   logic [dataWidth-1:0] pattern;
   logic                 rdPend;     // Read issued last cycle
   logic [dataWidth-1:0] expD;
   logic [addrWidth-1:0] addrD;
   logic                 mismatch;

   always_comb begin
      for (int i = 0; i < dataWidth; i++) begin
         ckPattern[i] = i[0];   // Bit 0 low
      end
   end

   assign pattern = (bg == bgChecker) ? ckPattern : '0;
   assign bistDin = pattern ^ {dataWidth{invert}};   // Also the expected read word

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // One-stage compare pipeline
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk) begin
      if (!rstN) begin
         rdPend <= 1'b0;
      end else begin
         rdPend <= bistOpValid && (bistOp == opRead);
      end
   end

   always_ff @(posedge clk) begin
      expD  <= bistDin;
      addrD <= addr;
   end

   assign mismatch = rdPend && (q != expD);

   always_ff @(posedge clk) begin
      if (!rstN || start) begin
         fail     <= 1'b0;
         failAddr <= '0;
         failData <= '0;
      end else if (mismatch && !fail) begin
         fail     <= 1'b1;
         failAddr <= addrD;
         failData <= q;
      end
   end

endmodule

// ==== source/marchFsm.sv ====
// March C- sequencer; runs solid then checkerboard background, never stalls, ignores start while busy

module marchFsm (
   input  logic                 clk,
   input  logic                 rstN,
   input  logic                 start,
   input  logic                 addrLast,
   output logic                 addrLoad,
   output logic                 addrStep,
   output logic                 addrDown,
   output logic                 bistOpValid,
   output mbistPkg::marchOpT    bistOp,
   output logic                 invert,
   output mbistPkg::backgroundT bg,
   output logic                 busy,
   output logic                 done
);
   import mbistPkg::*;

   marchStateT state;
   logic       phase;      // High on the write of a pair
   logic       pairElem;
   logic       opLast;     // Last operation at this address
   logic       elemEnd;
   logic       runEnd;

   assign pairElem = (state == element1) || (state == element2) ||
                     (state == element3) || (state == element4);
   assign opLast   = bistOpValid && (!pairElem || phase);
   assign elemEnd  = opLast && addrLast;
   assign runEnd   = elemEnd && (state == element5) && (bg == bgChecker);

   assign busy        = (state != idle);
   assign bistOpValid = (state != idle) && (state != finish);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Address counter control
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // The next element's first address is loaded on the last operation of
   // the current one, so elements follow back to back
   assign addrLoad = ((state == idle) && start) || (elemEnd && !runEnd);
   assign addrStep = opLast && !addrLast;
   assign addrDown = (state == element2) || (state == element3);   // Next is descending

   always_comb begin
      case (state)
         element0: bistOp = opWrite;
         element1,
         element2,
         element3,
         element4: bistOp = phase ? opWrite : opRead;
         default:  bistOp = opRead;
      endcase
   end

   always_comb begin
      case (state)
         element1,
         element3: invert = phase;    // Read bg, write inverse
         element2,
         element4: invert = !phase;   // Read inverse, write bg
         default:  invert = 1'b0;
      endcase
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // State register
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk) begin
      if (!rstN) begin
         state <= idle;
         phase <= 1'b0;
         bg    <= bgSolid;
         done  <= 1'b0;
      end else begin
         done  <= 1'b0;
         phase <= pairElem ? !phase : 1'b0;
         case (state)
            idle: begin
               if (start) begin
                  state <= element0;
                  bg    <= bgSolid;
               end
            end
            element0: if (elemEnd) state <= element1;
            element1: if (elemEnd) state <= element2;
            element2: if (elemEnd) state <= element3;
            element3: if (elemEnd) state <= element4;
            element4: if (elemEnd) state <= element5;
            element5: begin
               if (runEnd) begin
                  state <= finish;
               end else if (elemEnd) begin
                  state <= element0;   // Second background
                  bg    <= bgChecker;
               end
            end
            default: begin
               state <= idle;   // Finish, last compare lands now
               done  <= 1'b1;
            end
         endcase
      end
   end

endmodule

// ==== source/mbistPkg.sv ====
// March C- engine types; state order matters since the FSM walks elements in sequence

package mbistPkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // March sequencing
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef enum logic [2:0] {
      idle,
      element0,   // Write background
      element1,   // Up, read bg then write inverse
      element2,   // Up, read inverse then write bg
      element3,   // Down, read bg then write inverse
      element4,   // Down, read inverse then write bg
      element5,   // Read background
      finish      // Drain the compare stage
   } marchStateT;

   typedef enum logic {
      opRead,
      opWrite
   } marchOpT;

   typedef enum logic {
      bgSolid,    // All zeros
      bgChecker   // Bit i holds i mod 2
   } backgroundT;

endpackage

// ==== source/sramBistTop.sv ====
// BIST top for one two-port register file; functional requests are dropped while busy is high

module sramBistTop #(
   parameter int memDepth  = sramPkg::MemDepthDef,
   parameter int addrWidth = sramPkg::AddrWidthDef,
   parameter int dataWidth = sramPkg::DataWidthDef
) (
   input  logic                            clk,
   input  logic                            rstN,
   input  logic                            start,
   input  logic [sramPkg::ConfigWidth-1:0] tpramConfig,
   input  logic                            fWeN,
   input  logic [addrWidth-1:0]            fWaddr,
   input  logic [dataWidth-1:0]            fDin,
   input  logic                            fReN,
   input  logic [addrWidth-1:0]            fRaddr,
   output logic [dataWidth-1:0]            q,
   output logic                            busy,
   output logic                            done,
   output logic                            fail,
   output logic [addrWidth-1:0]            failAddr,
   output logic [dataWidth-1:0]            failData
);
   import mbistPkg::*;

   logic                 addrLoad;
   logic                 addrStep;
   logic                 addrDown;
   logic                 addrLast;
   logic [addrWidth-1:0] bistAddr;
   logic                 bistOpValid;
   marchOpT              bistOp;
   logic                 invert;
   backgroundT           bg;
   logic [dataWidth-1:0] bistDin;
   logic                 bistWr;
   logic                 bistRd;
   logic                 ceaB;
   logic                 weaB;
   logic                 cebB;
   logic                 rebB;
   logic [addrWidth-1:0] addrA;
   logic [addrWidth-1:0] addrB;
   logic [dataWidth-1:0] memDin;

   marchFsm uMarchFsm (
      .clk        (clk),
      .rstN       (rstN),
      .start      (start),
      .addrLast   (addrLast),
      .addrLoad   (addrLoad),
      .addrStep   (addrStep),
      .addrDown   (addrDown),
      .bistOpValid(bistOpValid),
      .bistOp     (bistOp),
      .invert     (invert),
      .bg         (bg),
      .busy       (busy),
      .done       (done)
   );

   marchAddrGen #(
      .memDepth (memDepth),
      .addrWidth(addrWidth)
   ) uMarchAddrGen (
      .clk     (clk),
      .rstN    (rstN),
      .addrLoad(addrLoad),
      .addrStep(addrStep),
      .addrDown(addrDown),
      .addr    (bistAddr),
      .addrLast(addrLast)
   );

   marchDataChk #(
      .addrWidth(addrWidth),
      .dataWidth(dataWidth)
   ) uMarchDataChk (
      .clk        (clk),
      .rstN       (rstN),
      .start      (start),
      .bistOpValid(bistOpValid),
      .bistOp     (bistOp),
      .invert     (invert),
      .bg         (bg),
      .addr       (bistAddr),
      .q          (q),
      .bistDin    (bistDin),
      .fail       (fail),
      .failAddr   (failAddr),
      .failData   (failData)
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Port mux, BIST owns the memory while busy
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign bistWr = bistOpValid && (bistOp == opWrite);
   assign bistRd = bistOpValid && (bistOp == opRead);

   always_comb begin
      if (busy) begin
         ceaB   = !bistWr;
         weaB   = !bistWr;
         addrA  = bistAddr;
         memDin = bistDin;
         cebB   = !bistRd;
         rebB   = !bistRd;
         addrB  = bistAddr;   // Read and write share the March address
      end else begin
         ceaB   = fWeN;
         weaB   = fWeN;
         addrA  = fWaddr;
         memDin = fDin;
         cebB   = fReN;
         rebB   = fReN;
         addrB  = fRaddr;
      end
   end

   tpSramWrap #(
      .memDepth (memDepth),
      .addrWidth(addrWidth),
      .dataWidth(dataWidth)
   ) uTpSramWrap (
      .clkA       (clk),   // Both ports on one clock
      .clkB       (clk),
      .addrA      (addrA),
      .addrB      (addrB),
      .din        (memDin),
      .tpramConfig(tpramConfig),
      .ceaB       (ceaB),
      .cebB       (cebB),
      .weaB       (weaB),
      .rebB       (rebB),
      .q          (q)
   );

endmodule

// ==== source/sramPkg.sv ====
// Geometry defaults for the 32x80 two-port register file; memDepth must stay a power of two

package sramPkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Memory geometry defaults
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam int MemDepthDef  = 32;
   localparam int AddrWidthDef = 5;   // log2 of MemDepthDef
   localparam int DataWidthDef = 80;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Macro configuration bus
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Bits 2:0 and 5:3 are read/write margins, bit 6 is the sense-amp margin
   // and bit 8 disables column collision logic. Only the model's
   // retention input is picked out here.
   localparam int ConfigWidth  = 9;
   localparam int CfgRetBit    = 7;   // Retention-not, low holds contents

endpackage

// ==== source/tpSram.sv ====
// Behavioral two-port SRAM; no byte mask, power-up contents are unknown, same-edge read of a written word returns old data

module tpSram #(
   parameter int memDepth  = 32,
   parameter int addrWidth = 5,
   parameter int dataWidth = 80
) (
   input  logic                 clkA,
   input  logic                 clkB,
   input  logic [addrWidth-1:0] addrA,
   input  logic [addrWidth-1:0] addrB,
   input  logic [dataWidth-1:0] din,
   input  logic                 ceaB,
   input  logic                 cebB,
   input  logic                 weaB,
   input  logic                 rebB,
   input  logic                 retN,
   output logic [dataWidth-1:0] dout
);

   logic [dataWidth-1:0] mem [memDepth];
   logic                 wrEn;
   logic                 rdEn;

   assign wrEn = !ceaB && !weaB && retN;   // Retention blocks writes
   assign rdEn = !cebB && !rebB;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Port A, write
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clkA) begin
      if (wrEn) begin
         mem[addrA] <= din;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Port B, registered read
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clkB) begin
      if (rdEn) begin
         dout <= mem[addrB];   // Holds when no read
      end
   end

endmodule

// ==== source/tpSramWrap.sv ====
// Macro wrapper using the behavioral model only; margin and column-disable fields reach no logic here

module tpSramWrap #(
   parameter int memDepth  = 32,
   parameter int addrWidth = 5,
   parameter int dataWidth = 80
) (
   input  logic                           clkA,
   input  logic                           clkB,
   input  logic [addrWidth-1:0]           addrA,
   input  logic [addrWidth-1:0]           addrB,
   input  logic [dataWidth-1:0]           din,
   input  logic [sramPkg::ConfigWidth-1:0] tpramConfig,
   input  logic                           ceaB,
   input  logic                           cebB,
   input  logic                           weaB,
   input  logic                           rebB,
   output logic [dataWidth-1:0]           q
);
   import sramPkg::*;

   logic [dataWidth-1:0] memQ;

   tpSram #(
      .memDepth  (memDepth),
      .addrWidth (addrWidth),
      .dataWidth (dataWidth)
   ) u0TpSram (
      .clkA (clkA),
      .clkB (clkB),
      .addrA(addrA),
      .addrB(addrB),
      .din  (din),
      .ceaB (ceaB),
      .cebB (cebB),
      .weaB (weaB),
      .rebB (rebB),
      .retN (tpramConfig[CfgRetBit]),   // Real macros also take the margins
      .dout (memQ)
   );

   assign q = memQ;   // No output pipeline

endmodule
